// File: vlog.f
+incdir+include
design/video_pkg.sv
design/audio_pkg.sv
design/slow_clk_gen.sv
design/vga_timing.sv
design/lab_settings.sv
design/lab_top.sv
design/i2s_audio_out.sv
design/board_specific_top.sv
sim/tb_board.sv

// File: run_sim.sh
#!/bin/sh
# build the board testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_board -f vlog.f -o tb_board

# the testbench exits nonzero on failure, the log decides the result
./obj_dir/tb_board > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi

if ! grep -q "Simulation PASSED" sim.log; then
    exit 1
fi

// File: sim/tb_board.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module tb_board;

    // --------------------------------------------------
    // dut configuration with a slow tick every 10 cycles
    // --------------------------------------------------

    localparam clk_mhz       = 1;
    localparam slow_clk_hz   = 100000;
    localparam tick_period   = 10;
    localparam screen_width  = 16;
    localparam screen_height = 8;

    localparam h_total      = screen_width  + `H_FRONT + `H_SYNC + `H_BACK;
    localparam v_total      = screen_height + `V_FRONT + `V_SYNC + `V_BACK;
    localparam w_x          = $clog2(h_total);
    localparam w_y          = $clog2(v_total);
    localparam hs_start     = screen_width + `H_FRONT;
    localparam hs_end       = hs_start + `H_SYNC;
    localparam vs_start     = screen_height + `V_FRONT;
    localparam vs_end       = vs_start + `V_SYNC;
    localparam frame_cycles = h_total * v_total;

    // 32 bclks per audio frame of 2 * BCLK_HALF clk each
    localparam audio_frame = 64 * `BCLK_HALF;

    // four raster frames, about 30 audio frames and the key presses
    // come to roughly 42000 cycles
    localparam timeout_cycles = 60000;

    localparam logic [`W_SOUND - 1:0] ampl_pos = `W_SOUND'(`TONE_AMPL);
    localparam logic [`W_SOUND - 1:0] ampl_neg = `W_SOUND'(-(`TONE_AMPL));

    logic                  clk;
    logic                  reset;
    logic [1:0]            key_n;
    logic [5:0]            led_n;
    logic                  hsync;
    logic                  vsync;
    logic                  display_on;
    logic [w_x - 1:0]      x;
    logic [w_y - 1:0]      y;
    logic [`W_COLOR - 1:0] red;
    logic [`W_COLOR - 1:0] green;
    logic [`W_COLOR - 1:0] blue;
    logic                  bclk;
    logic                  lrclk;
    logic                  sdata;

    // raster model and bookkeeping
    int               cycle_count;
    int               since_reset;
    logic [w_x - 1:0] mx;
    logic [w_y - 1:0] my;
    logic [15:0]      lfsr;

    board_specific_top
    #(
        .clk_mhz       (clk_mhz),
        .slow_clk_hz   (slow_clk_hz),
        .screen_width  (screen_width),
        .screen_height (screen_height)
    )
    dut0
    (
        .clk        (clk),
        .reset      (reset),
        .key_n      (key_n),
        .led_n      (led_n),
        .hsync      (hsync),
        .vsync      (vsync),
        .display_on (display_on),
        .x          (x),
        .y          (y),
        .red        (red),
        .green      (green),
        .blue       (blue),
        .bclk       (bclk),
        .lrclk      (lrclk),
        .sdata      (sdata)
    );

    // 20 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // --------------------------------------------------
    // failure handling and compare tasks
    // --------------------------------------------------

    task automatic fail_run(input string why);
        $display("Simulation FAILED");
        $fatal(1, "%s", why);
    endtask

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles)
            fail_run("timeout, the tests did not finish within the cycle limit");
    end

    task automatic check_level(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("single bit output mismatch");
        end
    endtask

    task automatic check_position
    (
        input string            name,
        input logic [w_x - 1:0] expected,
        input logic [w_x - 1:0] actual
    );
        if (actual !== expected)
        begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("raster position mismatch");
        end
    endtask

    task automatic check_color
    (
        input string                 name,
        input logic [`W_COLOR - 1:0] expected,
        input logic [`W_COLOR - 1:0] actual
    );
        if (actual !== expected)
        begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("color channel mismatch");
        end
    endtask

    task automatic check_sample
    (
        input string                 name,
        input logic [`W_SOUND - 1:0] expected,
        input logic [`W_SOUND - 1:0] actual
    );
        if (actual !== expected)
        begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("audio word mismatch");
        end
    endtask

    task automatic check_led
    (
        input string      name,
        input logic [5:0] expected,
        input logic [5:0] actual
    );
        if (actual !== expected)
        begin
            $display("error: %s expected 0x%h actual 0x%h", name, expected, actual);
            fail_run("led word mismatch");
        end
    endtask

    // --------------------------------------------------
    // stimulus helpers
    // --------------------------------------------------

    // one clk cycle with inputs changing 1 ns after the edge
    // the raster model steps along with the dut
    task automatic step();
        @(posedge clk);
        #1;
        since_reset = since_reset + 1;
        if (mx == w_x'(h_total - 1))
        begin
            mx = '0;
            my = (my == w_y'(v_total - 1)) ? '0 : my + 1'b1;
        end
        else
            mx = mx + 1'b1;
    endtask

    // two cycles of reset
    // returns in the first cycle after release
    task automatic apply_reset();
        reset = 1'b1;
        key_n = 2'b11;
        repeat (2)
            @(posedge clk);
        #1;
        reset       = 1'b0;
        since_reset = 0;
        mx          = '0;
        my          = '0;
    endtask

    // keys are active low at the pins
    task automatic press_key(input int idx);
        key_n[idx] = 1'b0;
        repeat (4)
            step();
        key_n[idx] = 1'b1;
        repeat (5)
            step();
    endtask

    // fibonacci lfsr with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | int'(lfsr[0]);
        end
    endtask

    // expected {red, green, blue} for a pixel
    function automatic logic [3 * `W_COLOR - 1:0] pattern_rgb
    (
        input video_pkg::pattern_t p,
        input logic [w_x - 1:0]    px,
        input logic [w_y - 1:0]    py
    );
        // blank outside the visible area
        if (!(int'(px) < screen_width && int'(py) < screen_height))
            return '0;
        case (p)
            video_pkg::pattern_bars:
                return {{`W_COLOR{px[w_x - 1]}}, {`W_COLOR{py[w_y - 1]}}, {`W_COLOR{1'b0}}};
            video_pkg::pattern_checker:
                return {3 * `W_COLOR{px[2] ^ py[2]}};
            video_pkg::pattern_solid:
                return {{2 * `W_COLOR{1'b0}}, {`W_COLOR{1'b1}}};
            default:
                return '0;
        endcase
    endfunction

    task automatic check_pixel(input video_pkg::pattern_t p);
        logic [3 * `W_COLOR - 1:0] rgb;
        rgb = pattern_rgb(p, mx, my);
        check_color("red", rgb[3 * `W_COLOR - 1:2 * `W_COLOR], red);
        check_color("green", rgb[2 * `W_COLOR - 1:`W_COLOR], green);
        check_color("blue", rgb[`W_COLOR - 1:0], blue);
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic test_reset_state();
        apply_reset();
        check_level("hsync", 1'b1, hsync);
        check_level("vsync", 1'b1, vsync);
        check_level("display_on", 1'b1, display_on);
        check_position("x", '0, x);
        check_position("y", '0, w_x'(y));
        check_led("led_n", 6'h3f, led_n);
        check_level("bclk", 1'b0, bclk);
        check_level("lrclk", 1'b0, lrclk);
        check_level("sdata", 1'b0, sdata);
    endtask

    // every cycle of one frame against the raster model
    task automatic test_raster();
        logic exp_on;
        logic exp_hs;
        logic exp_vs;
        apply_reset();
        for (int i = 0; i < frame_cycles; i++)
        begin
            exp_on = (int'(mx) < screen_width) && (int'(my) < screen_height);
            exp_hs = !(int'(mx) >= hs_start && int'(mx) < hs_end);
            exp_vs = !(int'(my) >= vs_start && int'(my) < vs_end);
            check_position("x", mx, x);
            check_position("y", w_x'(my), w_x'(y));
            check_level("display_on", exp_on, display_on);
            check_level("hsync", exp_hs, hsync);
            check_level("vsync", exp_vs, vsync);
            step();
        end
    endtask

    task automatic test_patterns();
        video_pkg::pattern_t order [3];
        int                  gap;
        int                  start;
        order[0] = video_pkg::pattern_bars;
        order[1] = video_pkg::pattern_checker;
        order[2] = video_pkg::pattern_solid;
        apply_reset();
        for (int n = 0; n < 3; n++)
        begin
            if (n > 0)
                press_key(0);
            // random sample points over a whole frame
            start = since_reset;
            while (since_reset - start < frame_cycles)
            begin
                random_bits(5, gap);
                repeat (gap + 1)
                    step();
                check_pixel(order[n]);
            end
        end
        // solid wraps back to bars
        press_key(0);
        check_pixel(video_pkg::pattern_bars);
    endtask

    // tick count k shows from cycle 10k+1
    task automatic test_slow_tick();
        logic [3:0] count;
        apply_reset();
        for (int k = 0; k <= 20; k++)
        begin
            while (since_reset < tick_period * k + 1)
                step();
            count = 4'(k % 16);
            check_led("led_n", ~{2'b00, count}, led_n);
        end
    endtask

    task automatic test_tone_select();
        audio_pkg::tone_t order [3];
        logic [3:0]       count;
        order[0] = audio_pkg::tone_low;
        order[1] = audio_pkg::tone_high;
        order[2] = audio_pkg::tone_off;
        apply_reset();
        for (int n = 0; n < 3; n++)
        begin
            press_key(1);
            count = 4'((since_reset - 1) / tick_period);
            check_led("led_n", ~{order[n], count}, led_n);
        end
    endtask

    // deserialize sdata on bclk rising edges
    // a word ends with the first bit after the next lrclk change
    task automatic collect_words(input audio_pkg::tone_t expect_tone, input int frames);
        logic [`W_SOUND - 1:0] word;
        logic [`W_SOUND - 1:0] left_word;
        logic                  prev_bclk;
        logic                  prev_lr;
        logic                  exp_lr;
        logic                  synced;
        logic                  have_word;
        logic                  have_left;
        logic                  seen_pos;
        logic                  seen_neg;
        int                    slot;
        int                    words;
        int                    stop;
        word      = '0;
        left_word = '0;
        prev_bclk = bclk;
        prev_lr   = lrclk;
        exp_lr    = lrclk;
        synced    = 1'b0;
        have_word = 1'b0;
        have_left = 1'b0;
        seen_pos  = 1'b0;
        seen_neg  = 1'b0;
        slot      = 0;
        words     = 0;
        stop      = since_reset + frames * audio_frame;
        while (since_reset < stop)
        begin
            step();
            // lrclk moves only together with a falling bclk
            if (lrclk !== prev_lr)
            begin
                check_level("bclk", 1'b0, bclk);
                check_level("bclk before lrclk change", 1'b1, prev_bclk);
            end
            if (bclk && !prev_bclk)
            begin
                if (synced)
                begin
                    slot = slot + 1;
                    if (slot == 16)
                    begin
                        slot   = 0;
                        exp_lr = ~exp_lr;
                    end
                    check_level("lrclk", exp_lr, lrclk);
                    word = {word[`W_SOUND - 2:0], sdata};
                    if (slot == 0 && have_word)
                    begin
                        words = words + 1;
                        if (expect_tone == audio_pkg::tone_off)
                            check_sample("sdata word", '0, word);
                        else if (word === ampl_pos)
                            seen_pos = 1'b1;
                        else if (word === ampl_neg)
                            seen_neg = 1'b1;
                        else
                            check_sample("sdata word", ampl_pos, word);
                        // right word repeats the left word of its frame
                        if (lrclk)
                        begin
                            left_word = word;
                            have_left = 1'b1;
                        end
                        else if (have_left)
                            check_sample("right word", left_word, word);
                    end
                    if (slot == 0)
                        have_word = 1'b1;
                end
                else if (lrclk !== exp_lr)
                begin
                    // first lrclk change fixes the slot grid
                    synced = 1'b1;
                    exp_lr = lrclk;
                    slot   = 0;
                end
            end
            prev_bclk = bclk;
            prev_lr   = lrclk;
        end
        if (words < frames)
            fail_run("sdata delivered fewer audio words than the frames allow");
        if (expect_tone == audio_pkg::tone_high && !(seen_pos && seen_neg))
            fail_run("high tone did not send both square wave levels");
    endtask

    // the low tone period equals the audio frame so its capture phase
    // stays fixed and only the high tone must show both levels
    task automatic test_audio();
        apply_reset();
        collect_words(audio_pkg::tone_off, 8);
        press_key(1);
        repeat (2 * audio_frame)
            step();
        collect_words(audio_pkg::tone_low, 8);
        press_key(1);
        repeat (2 * audio_frame)
            step();
        collect_words(audio_pkg::tone_high, 8);
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------

    initial
    begin
        reset       = 1'b1;
        key_n       = 2'b11;
        lfsr        = 16'd16;
        cycle_count = 0;
        since_reset = 0;
        mx          = '0;
        my          = '0;

        test_reset_state();
        test_raster();
        test_patterns();
        test_slow_tick();
        test_tone_select();
        test_audio();

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: design/board_specific_top.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module board_specific_top
#(
    parameter  clk_mhz       = 25,
    parameter  slow_clk_hz   = 1,
    parameter  screen_width  = 640,
    parameter  screen_height = 480,

    localparam w_x = $clog2(screen_width  + `H_FRONT + `H_SYNC + `H_BACK),
    localparam w_y = $clog2(screen_height + `V_FRONT + `V_SYNC + `V_BACK)
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [1:0]            key_n,
    output logic [5:0]            led_n,
    output logic                  hsync,
    output logic                  vsync,
    output logic                  display_on,
    output logic [w_x - 1:0]      x,
    output logic [w_y - 1:0]      y,
    output logic [`W_COLOR - 1:0] red,
    output logic [`W_COLOR - 1:0] green,
    output logic [`W_COLOR - 1:0] blue,
    output logic                  bclk,
    output logic                  lrclk,
    output logic                  sdata
);

    logic [1:0]            key;
    logic [5:0]            lab_led;
    logic                  slow_clk;
    video_pkg::pattern_t   pattern;
    audio_pkg::tone_t      tone;
    logic [`W_SOUND - 1:0] sound;

    // board keys and leds are active low
    assign key   = ~key_n;
    assign led_n = ~lab_led;

    // --------------------------------------------------
    // clocking and raster
    // --------------------------------------------------

    slow_clk_gen #(.fast_clk_mhz (clk_mhz), .slow_clk_hz (slow_clk_hz))
    i_slow_clk_gen (.clk (clk), .reset (reset), .slow_clk (slow_clk));

    // pixel clock is clk itself, no pll
    vga_timing #(.screen_width (screen_width), .screen_height (screen_height))
    i_vga_timing
    (
        .clk (clk), .reset (reset), .hsync (hsync), .vsync (vsync),
        .display_on (display_on), .x (x), .y (y)
    );

    // --------------------------------------------------
    // lab design and its settings
    // --------------------------------------------------

    lab_settings i_lab_settings
        (.clk (clk), .reset (reset), .key (key), .pattern (pattern), .tone (tone));

    lab_top #(.w_x (w_x), .w_y (w_y)) i_lab_top
    (
        .clk (clk), .reset (reset), .slow_clk (slow_clk),
        .x (x), .y (y), .display_on (display_on),
        .pattern (pattern), .tone (tone),
        .red (red), .green (green), .blue (blue),
        .sound (sound), .led (lab_led)
    );

    // dac stream out
    i2s_audio_out i_i2s_audio_out
    (
        .clk (clk), .reset (reset), .sound (sound),
        .bclk (bclk), .lrclk (lrclk), .sdata (sdata)
    );

endmodule

// File: design/i2s_audio_out.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module i2s_audio_out
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`W_SOUND - 1:0] sound,
    output logic                  bclk,
    output logic                  lrclk,
    output logic                  sdata
);

    localparam w_div  = `BCLK_HALF > 1 ? $clog2(`BCLK_HALF) : 1;
    localparam w_bit  = $clog2(`W_SOUND);
    localparam w_slot = w_bit + 1;

    logic [w_div - 1:0]    div_cnt;
    logic                  bclk_edge;
    logic                  bclk_fall;
    logic [w_slot - 1:0]   slot;
    logic [w_slot - 1:0]   slot_next;
    audio_pkg::channel_t   channel;
    logic [`W_SOUND - 1:0] sample;
    logic [`W_SOUND - 1:0] shift;

    // --------------------------------------------------
    // bit clock divider
    // --------------------------------------------------

    assign bclk_edge = (div_cnt == w_div'(`BCLK_HALF - 1));
    assign bclk_fall = bclk_edge && bclk;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (bclk_edge)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // --------------------------------------------------
    // slot counter and channel
    // --------------------------------------------------

    // frame is two words of bclk slots, top slot bit is the channel
    assign slot_next = slot + 1'b1;

    // starting at the last slot makes the first fall open a frame
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            slot    <= '1;
            channel <= audio_pkg::channel_left;
        end
        else if (bclk_fall)
        begin
            slot    <= slot_next;
            channel <= slot_next[w_slot - 1] ? audio_pkg::channel_right
                                             : audio_pkg::channel_left;
        end
    end

    assign lrclk = (channel == audio_pkg::channel_right);

    // one capture per frame, both channels send it
    always_ff @(posedge clk)
    begin
        if (bclk_fall && slot_next == '0)
            sample <= sound;
    end

    // msb goes out one bclk after the lrclk change
    // lsb lands in the first slot of the other channel
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            shift <= '0;
            sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            if (slot_next[w_bit - 1:0] == w_bit'(1))
            begin
                sdata <= sample[`W_SOUND - 1];
                shift <= {sample[`W_SOUND - 2:0], 1'b0};
            end
            else
            begin
                sdata <= shift[`W_SOUND - 1];
                shift <= {shift[`W_SOUND - 2:0], 1'b0};
            end
        end
    end

    // word select only moves with a falling bclk
    assert property (@(posedge clk) disable iff (reset)
        $changed(lrclk) |-> $fell(bclk))
        else $error("lrclk changed away from a bclk falling edge");

endmodule

// File: design/lab_top.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module lab_top
#(
    parameter w_x = 10,
    parameter w_y = 10
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  slow_clk,
    input  logic [w_x - 1:0]      x,
    input  logic [w_y - 1:0]      y,
    input  logic                  display_on,
    input  video_pkg::pattern_t   pattern,
    input  audio_pkg::tone_t      tone,
    output logic [`W_COLOR - 1:0] red,
    output logic [`W_COLOR - 1:0] green,
    output logic [`W_COLOR - 1:0] blue,
    output logic [`W_SOUND - 1:0] sound,
    output logic [5:0]            led
);

    localparam w_half = $clog2(`TONE_LOW_HALF + `TONE_HIGH_HALF);

    localparam logic [`W_SOUND - 1:0] ampl = `W_SOUND'(`TONE_AMPL);

    logic                  checker_on;
    logic [w_half - 1:0]   half_cnt;
    logic [w_half - 1:0]   half_reload;
    logic                  phase;
    logic [3:0]            tick_cnt;

    // --------------------------------------------------
    // pattern decode in the same cycle as x and y
    // --------------------------------------------------

    assign checker_on = x[2] ^ y[2];

    always_comb
    begin
        red   = '0;
        green = '0;
        blue  = '0;

        // blank outside the visible area
        if (display_on)
        begin
            case (pattern)
                video_pkg::pattern_bars:
                begin
                    red   = {`W_COLOR{x[w_x - 1]}};
                    green = {`W_COLOR{y[w_y - 1]}};
                end
                video_pkg::pattern_checker:
                begin
                    red   = {`W_COLOR{checker_on}};
                    green = {`W_COLOR{checker_on}};
                    blue  = {`W_COLOR{checker_on}};
                end
                video_pkg::pattern_solid:
                    blue  = '1;
                default: ;
            endcase
        end
    end

    // --------------------------------------------------
    // square wave tone
    // --------------------------------------------------

    assign half_reload = (tone == audio_pkg::tone_high) ? w_half'(`TONE_HIGH_HALF - 1)
                                                        : w_half'(`TONE_LOW_HALF - 1);

    // phase flips every half period and idles while off
    always_ff @(posedge clk)
    begin
        if (reset || tone == audio_pkg::tone_off)
        begin
            half_cnt <= '0;
            phase    <= 1'b0;
        end
        else if (half_cnt == '0)
        begin
            half_cnt <= half_reload;
            phase    <= ~phase;
        end
        else
            half_cnt <= half_cnt - 1'b1;
    end

    // two's complement negative half of the wave
    assign sound = (tone == audio_pkg::tone_off) ? '0
                 : phase                         ? ampl
                 :                                 (~ampl + 1'b1);

    // led word has the tick count low and the tone code high
    always_ff @(posedge clk)
    begin
        if (reset)
            tick_cnt <= '0;
        else if (slow_clk)
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign led = {tone, tick_cnt};

endmodule

// File: design/lab_settings.sv
`timescale 1ns/1ps

module lab_settings
(
    input  logic                clk,
    input  logic                reset,
    input  logic [1:0]          key,
    output video_pkg::pattern_t pattern,
    output audio_pkg::tone_t    tone
);

    logic [1:0] key_meta;
    logic [1:0] key_sync;
    logic [1:0] key_prev;
    logic [1:0] press;

    // two flop synchronizer plus the edge register
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    // one cycle pulse on each press
    assign press = key_sync & ~key_prev;

    // --------------------------------------------------
    // settings registers, stepped cyclically
    // --------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pattern <= video_pkg::pattern_bars;
            tone    <= audio_pkg::tone_off;
        end
        else
        begin
            if (press[0])
            begin
                case (pattern)
                    video_pkg::pattern_bars:    pattern <= video_pkg::pattern_checker;
                    video_pkg::pattern_checker: pattern <= video_pkg::pattern_solid;
                    default:                    pattern <= video_pkg::pattern_bars;
                endcase
            end

            if (press[1])
            begin
                case (tone)
                    audio_pkg::tone_off: tone <= audio_pkg::tone_low;
                    audio_pkg::tone_low: tone <= audio_pkg::tone_high;
                    default:             tone <= audio_pkg::tone_off;
                endcase
            end
        end
    end

    // code 3 must never reach the lab design
    assert property (@(posedge clk) disable iff (reset)
        (pattern inside {video_pkg::pattern_bars, video_pkg::pattern_checker,
                         video_pkg::pattern_solid})
        && (tone inside {audio_pkg::tone_off, audio_pkg::tone_low,
                         audio_pkg::tone_high}))
        else $error("settings register holds an unused code");

endmodule

// File: design/vga_timing.sv
`timescale 1ns/1ps
`include "board_macros.svh"

module vga_timing
#(
    parameter  screen_width  = 640,
    parameter  screen_height = 480,

    // full raster including porches and sync
    localparam h_total = screen_width  + `H_FRONT + `H_SYNC + `H_BACK,
    localparam v_total = screen_height + `V_FRONT + `V_SYNC + `V_BACK,
    localparam w_x     = $clog2(h_total),
    localparam w_y     = $clog2(v_total)
)
(
    input  logic             clk,
    input  logic             reset,
    output logic             hsync,
    output logic             vsync,
    output logic             display_on,
    output logic [w_x - 1:0] x,
    output logic [w_y - 1:0] y
);

    // decode thresholds at counter width
    localparam logic [w_x - 1:0] x_last   = w_x'(h_total - 1);
    localparam logic [w_y - 1:0] y_last   = w_y'(v_total - 1);
    localparam logic [w_x - 1:0] x_disp   = w_x'(screen_width);
    localparam logic [w_y - 1:0] y_disp   = w_y'(screen_height);
    localparam logic [w_x - 1:0] hs_start = w_x'(screen_width + `H_FRONT);
    localparam logic [w_x - 1:0] hs_end   = w_x'(screen_width + `H_FRONT + `H_SYNC);
    localparam logic [w_y - 1:0] vs_start = w_y'(screen_height + `V_FRONT);
    localparam logic [w_y - 1:0] vs_end   = w_y'(screen_height + `V_FRONT + `V_SYNC);

    logic [w_x - 1:0] x_next;
    logic [w_y - 1:0] y_next;

    // --------------------------------------------------
    // next raster position
    // --------------------------------------------------

    always_comb
    begin
        x_next = x + 1'b1;
        y_next = y;

        // end of line, step to the next one
        if (x == x_last)
        begin
            x_next = '0;

            if (y == y_last)
                y_next = '0;
            else
                y_next = y + 1'b1;
        end
    end

    // --------------------------------------------------
    // counters and registered decodes
    // --------------------------------------------------

    // decodes use the next position so they line up with x and y
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x          <= '0;
            y          <= '0;
            display_on <= 1'b1;
            hsync      <= 1'b1;
            vsync      <= 1'b1;
        end
        else
        begin
            x          <= x_next;
            y          <= y_next;
            display_on <= (x_next < x_disp) && (y_next < y_disp);
            hsync      <= !((x_next >= hs_start) && (x_next < hs_end));
            vsync      <= !((y_next >= vs_start) && (y_next < vs_end));
        end
    end

    // enable never leaks into porches or sync
    assert property (@(posedge clk) disable iff (reset)
        display_on |-> (x < x_disp) && (y < y_disp))
        else $error("display_on outside the visible area");

endmodule

// File: design/slow_clk_gen.sv
`timescale 1ns/1ps

module slow_clk_gen
#(
    parameter fast_clk_mhz = 25,
    parameter slow_clk_hz  = 1
)
(
    input  logic clk,
    input  logic reset,
    output logic slow_clk
);

    // clk cycles between two ticks
    localparam period = fast_clk_mhz * 1000000 / slow_clk_hz;
    localparam w_cnt  = period > 1 ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    // down counter, tick is registered off the zero state
    // so the first tick shows up period cycles after reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cnt      <= w_cnt'(period - 1);
            slow_clk <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt      <= w_cnt'(period - 1);
            slow_clk <= 1'b1;
        end
        else
        begin
            cnt      <= cnt - 1'b1;
            slow_clk <= 1'b0;
        end
    end

    // --------------------------------------------------
    // checks
    // --------------------------------------------------

    // the tick is a single cycle pulse
    assert property (@(posedge clk) disable iff (reset)
        slow_clk |=> !slow_clk)
        else $error("slow_clk held high for two cycles");

endmodule

// File: design/audio_pkg.sv
package audio_pkg;

    // --------------------------------------------------
    // tone selection
    // --------------------------------------------------

    // off must stay code 0, the leds show it as all ones
    typedef enum logic [1:0]
    {
        tone_off  = 2'd0,
        tone_low  = 2'd1,
        tone_high = 2'd2
    } tone_t;

    // I2S channel, matches the lrclk level
    typedef enum logic
    {
        channel_left  = 1'b0,
        channel_right = 1'b1
    } channel_t;

endpackage

// File: design/video_pkg.sv
package video_pkg;

    // --------------------------------------------------
    // test pattern selection
    // --------------------------------------------------

    // key 0 walks through these in declaration order
    // code 3 is never used
    typedef enum logic [1:0]
    {
        // red from top x bit, green from top y bit
        pattern_bars    = 2'd0,

        // white where x[2] and y[2] differ
        pattern_checker = 2'd1,

        // plain blue screen
        pattern_solid   = 2'd2
    } pattern_t;

endpackage

// File: include/board_macros.svh
`ifndef BOARD_MACROS_SVH
`define BOARD_MACROS_SVH

// horizontal raster, in pixels past the visible area
`define H_FRONT        16
`define H_SYNC         96
`define H_BACK         48

// vertical raster, in lines past the visible area
`define V_FRONT        10
`define V_SYNC         2
`define V_BACK         33

// clk cycles per bclk half period
`define BCLK_HALF      2

// audio sample and color channel widths
`define W_SOUND        16
`define W_COLOR        8

// square wave magnitude and half periods in clk cycles
`define TONE_AMPL      'h2000
`define TONE_LOW_HALF  64
`define TONE_HIGH_HALF 24

`endif
